//--- cp0_consts.svh
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// CP0 register numbers (rd field)
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15

// Cause.ExcCode values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_CPU  5'd11
`define EXC_OV   5'd12
`define EXC_TR   5'd13

`define VEC_BOOT   32'hBFC00380 // Status.BEV set
`define VEC_NORMAL 32'h80000180

`define PRID_VALUE 32'h00018000

// Software-writable bits of Status and Cause
`define STATUS_WMASK 32'h1040FF17
`define CAUSE_WMASK  32'h00000300

// Status bits forced at reset
`define CP0_RST_BEV 1'b1
`define CP0_RST_ERL 1'b1

// COP0 instruction encoding
`define OPC_COP0   6'b010000
`define RS_MF      5'b00000
`define RS_MT      5'b00100
`define FUNCT_ERET 6'b011000

`endif

//--- cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    // MFC0 / MTC0 layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [7:0] zero;
        logic [2:0] sel;
    } cop0Move_s;

    // ERET and other CO=1 operations
    typedef struct packed {
        logic [5:0]  opcode;
        logic        co;
        logic [18:0] zero;
        logic [5:0]  funct;
    } cop0Co_s;

    // One instruction word, two decodings
    typedef union packed {
        cop0Move_s move;
        cop0Co_s   cop;
    } cop0Instr_u;

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_MFC0 = 2'd1,
        OP_MTC0 = 2'd2,
        OP_ERET = 2'd3
    } cp0Op_e;

endpackage

`default_nettype wire

//--- cp0Decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_consts.svh"

module cp0Decode (
    input  wire               clk,
    input  wire               rst,
    input  wire               instrValid_i,
    input  wire        [31:0] instr_i,
    input  wire        [31:0] rtData_i,
    output logic              decValid_o,
    output cp0_pkg::cp0Op_e   decOp_o,
    output logic       [4:0]  decReg_o,
    output logic       [31:0] decWdata_o
);

    cp0_pkg::cop0Instr_u instrU;
    cp0_pkg::cp0Op_e     op;
    logic                isCop0;

    assign instrU = instr_i;
    assign isCop0 = (instrU.move.opcode == `OPC_COP0);

    always_comb begin
        op = cp0_pkg::OP_NONE;
        if (isCop0) begin
            if (instrU.cop.co) begin
                if (instrU.cop.funct == `FUNCT_ERET)
                    op = cp0_pkg::OP_ERET;
            end else if (instrU.move.rs == `RS_MF) begin
                op = cp0_pkg::OP_MFC0;
            end else if (instrU.move.rs == `RS_MT) begin
                op = cp0_pkg::OP_MTC0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decValid_o <= 1'b0;
            decOp_o    <= cp0_pkg::OP_NONE;
        end else begin
            decValid_o <= instrValid_i && (op != cp0_pkg::OP_NONE); // Drop non-CP0 words
            decOp_o    <= op;
        end
    end

    // Payload captured with the instruction
    always_ff @(posedge clk) begin
        if (instrValid_i) begin
            decReg_o   <= instrU.move.rd;
            decWdata_o <= rtData_i;
        end
    end

    aDecValidOp: assert property (@(posedge clk) disable iff (rst)
        decValid_o |-> decOp_o != cp0_pkg::OP_NONE);

endmodule

`default_nettype wire

//--- cp0Regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_consts.svh"

module cp0Regs (
    input  wire              clk,
    input  wire              rst,
    input  wire              decValid_i,
    input  wire cp0_pkg::cp0Op_e decOp_i,
    input  wire       [4:0]  decReg_i,
    input  wire       [31:0] decWdata_i,
    input  wire              excValid_i,
    input  wire       [4:0]  excCode_i,
    input  wire       [31:0] excPc_i,
    input  wire       [31:0] excBadVAddr_i,
    input  wire              excInSlot_i,
    input  wire       [1:0]  excCpNum_i,
    input  wire       [5:0]  hwInt_i,
    output logic             readValid_o,
    output logic      [31:0] readData_o,
    output logic             redirect_o,
    output logic      [31:0] redirectPc_o,
    output logic             timerInt_o,
    output logic             intPending_o,
    output logic             userMode_o
);

    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] epc;

    logic       statusCu0;
    logic       statusBev;
    logic [7:0] statusIm;
    logic       statusUm;
    logic       statusErl;
    logic       statusExl;
    logic       statusIe;

    logic       causeBd;
    logic [1:0] causeCe;
    logic [5:0] ipHw;   // Sampled hwInt_i
    logic [1:0] ipSw;
    logic [4:0] causeExc;

    logic [7:0]  causeIp;
    logic [31:0] statusWord;
    logic [31:0] causeWord;
    logic [31:0] rdWord;
    logic        timerHit;
    logic        instrGo;

    assign instrGo  = decValid_i && !excValid_i; // Exception wins over execute
    assign timerHit = (compare != 32'd0) && (count == compare);
    assign causeIp  = {ipHw[5] | timerInt_o, ipHw[4:0], ipSw};

    assign statusWord = {3'b0, statusCu0, 5'b0, statusBev, 6'b0, statusIm,
                         3'b0, statusUm, 1'b0, statusErl, statusExl, statusIe};
    assign causeWord  = {causeBd, 1'b0, causeCe, 12'b0, causeIp, 1'b0, causeExc, 2'b0};

    always_comb begin
        case (decReg_i)
            `CP0_REG_BADVADDR: rdWord = badVAddr;
            `CP0_REG_COUNT:    rdWord = count;
            `CP0_REG_COMPARE:  rdWord = compare;
            `CP0_REG_STATUS:   rdWord = statusWord;
            `CP0_REG_CAUSE:    rdWord = causeWord;
            `CP0_REG_EPC:      rdWord = epc;
            `CP0_REG_PRID:     rdWord = `PRID_VALUE;
            default:           rdWord = 32'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddr    <= 32'd0;
            count       <= 32'd0;
            compare     <= 32'd0;
            epc         <= 32'd0;
            statusCu0   <= 1'b0;
            statusBev   <= `CP0_RST_BEV;
            statusIm    <= 8'd0;
            statusUm    <= 1'b0;
            statusErl   <= `CP0_RST_ERL;
            statusExl   <= 1'b0;
            statusIe    <= 1'b0;
            causeBd     <= 1'b0;
            causeCe     <= 2'd0;
            ipHw        <= 6'd0;
            ipSw        <= 2'd0;
            causeExc    <= 5'd0;
            timerInt_o  <= 1'b0;
            readValid_o <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            readValid_o <= 1'b0;
            redirect_o  <= 1'b0;
            ipHw        <= hwInt_i;
            count       <= count + 32'd1; // Overridden by an MTC0 below
            if (timerHit)
                timerInt_o <= 1'b1;

            if (excValid_i) begin
                if (!statusExl) begin
                    epc     <= excInSlot_i ? excPc_i - 32'd4 : excPc_i;
                    causeBd <= excInSlot_i;
                end
                statusExl  <= 1'b1;
                causeExc   <= excCode_i;
                redirect_o <= 1'b1;
                if (excCode_i == `EXC_ADEL || excCode_i == `EXC_ADES)
                    badVAddr <= excBadVAddr_i;
                if (excCode_i == `EXC_CPU)
                    causeCe <= excCpNum_i;
            end else if (instrGo) begin
                case (decOp_i)
                    cp0_pkg::OP_MFC0: readValid_o <= 1'b1;
                    cp0_pkg::OP_ERET: begin
                        if (statusErl)
                            statusErl <= 1'b0;
                        else
                            statusExl <= 1'b0;
                        redirect_o <= 1'b1;
                    end
                    cp0_pkg::OP_MTC0: begin
                        case (decReg_i)
                            `CP0_REG_BADVADDR: badVAddr <= decWdata_i;
                            `CP0_REG_COUNT:    count    <= decWdata_i;
                            `CP0_REG_COMPARE: begin
                                compare    <= decWdata_i;
                                timerInt_o <= 1'b0; // Write acknowledges timer
                            end
                            `CP0_REG_STATUS: begin
                                statusCu0 <= decWdata_i[28];
                                statusBev <= decWdata_i[22];
                                statusIm  <= decWdata_i[15:8];
                                statusUm  <= decWdata_i[4];
                                statusErl <= decWdata_i[2];
                                statusExl <= decWdata_i[1];
                                statusIe  <= decWdata_i[0];
                            end
                            `CP0_REG_CAUSE:    ipSw <= decWdata_i[9:8];
                            `CP0_REG_EPC:      epc  <= decWdata_i;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data and target PC
    always_ff @(posedge clk) begin
        if (instrGo && decOp_i == cp0_pkg::OP_MFC0)
            readData_o <= rdWord;
        if (excValid_i)
            redirectPc_o <= statusBev ? `VEC_BOOT : `VEC_NORMAL;
        else if (instrGo && decOp_i == cp0_pkg::OP_ERET)
            redirectPc_o <= epc;
    end

    assign intPending_o = statusIe && !statusExl && !statusErl && |(causeIp & statusIm);
    assign userMode_o   = statusUm && !statusErl && !statusExl;

    aRedirectOrRead: assert property (@(posedge clk) disable iff (rst)
        !(redirect_o && readValid_o));

    // Timer only fires against a programmed Compare
    aTimerCompare: assert property (@(posedge clk) disable iff (rst)
        timerInt_o |-> compare != 32'd0);

endmodule

`default_nettype wire

//--- cp0Result.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Result (
    input  wire         clk,
    input  wire         rst,
    input  wire         readValid_i,
    input  wire  [31:0] readData_i,
    input  wire         redirect_i,
    input  wire  [31:0] redirectPc_i,
    output logic        resultValid_o,
    output logic [31:0] resultData_o,
    output logic        redirectValid_o,
    output logic [31:0] redirectPc_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid_o   <= 1'b0;
            redirectValid_o <= 1'b0;
        end else begin
            resultValid_o   <= readValid_i;
            redirectValid_o <= redirect_i;
        end
    end

    // Last value held between pulses
    always_ff @(posedge clk) begin
        if (readValid_i)
            resultData_o <= readData_i;
        if (redirect_i)
            redirectPc_o <= redirectPc_i;
    end

    aOneOutcome: assert property (@(posedge clk) disable iff (rst)
        !(resultValid_o && redirectValid_o));

endmodule

`default_nettype wire

//--- cp0Unit.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Unit (
    input  wire         clk,
    input  wire         rst,
    input  wire         instrValid_i,
    input  wire  [31:0] instr_i,
    input  wire  [31:0] rtData_i,
    input  wire         excValid_i,
    input  wire  [4:0]  excCode_i,
    input  wire  [31:0] excPc_i,
    input  wire  [31:0] excBadVAddr_i,
    input  wire         excInSlot_i,
    input  wire  [1:0]  excCpNum_i,
    input  wire  [5:0]  hwInt_i,
    output logic        resultValid_o,
    output logic [31:0] resultData_o,
    output logic        redirectValid_o,
    output logic [31:0] redirectPc_o,
    output logic        timerInt_o,
    output logic        intPending_o,
    output logic        userMode_o
);

    logic            decValid;
    cp0_pkg::cp0Op_e decOp;
    logic [4:0]      decReg;
    logic [31:0]     decWdata;

    logic            exeReadValid;
    logic [31:0]     exeReadData;
    logic            exeRedirect;
    logic [31:0]     exeRedirectPc;

    cp0Decode uDecode (
        .clk          (clk),
        .rst          (rst),
        .instrValid_i (instrValid_i),
        .instr_i      (instr_i),
        .rtData_i     (rtData_i),
        .decValid_o   (decValid),
        .decOp_o      (decOp),
        .decReg_o     (decReg),
        .decWdata_o   (decWdata)
    );

    cp0Regs uRegs (
        .clk           (clk),
        .rst           (rst),
        .decValid_i    (decValid),
        .decOp_i       (decOp),
        .decReg_i      (decReg),
        .decWdata_i    (decWdata),
        .excValid_i    (excValid_i),
        .excCode_i     (excCode_i),
        .excPc_i       (excPc_i),
        .excBadVAddr_i (excBadVAddr_i),
        .excInSlot_i   (excInSlot_i),
        .excCpNum_i    (excCpNum_i),
        .hwInt_i       (hwInt_i),
        .readValid_o   (exeReadValid),
        .readData_o    (exeReadData),
        .redirect_o    (exeRedirect),
        .redirectPc_o  (exeRedirectPc),
        .timerInt_o    (timerInt_o),
        .intPending_o  (intPending_o),
        .userMode_o    (userMode_o)
    );

    cp0Result uResult (
        .clk             (clk),
        .rst             (rst),
        .readValid_i     (exeReadValid),
        .readData_i      (exeReadData),
        .redirect_i      (exeRedirect),
        .redirectPc_i    (exeRedirectPc),
        .resultValid_o   (resultValid_o),
        .resultData_o    (resultData_o),
        .redirectValid_o (redirectValid_o),
        .redirectPc_o    (redirectPc_o)
    );

endmodule

`default_nettype wire

//--- tb_cp0Unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_consts.svh"

module tb_cp0Unit;

    localparam int FlagTimer = 0;
    localparam int FlagInt   = 1;
    localparam int FlagUser  = 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid_i;
    logic [31:0] instr_i;
    logic [31:0] rtData_i;
    logic        excValid_i;
    logic [4:0]  excCode_i;
    logic [31:0] excPc_i;
    logic [31:0] excBadVAddr_i;
    logic        excInSlot_i;
    logic [1:0]  excCpNum_i;
    logic [5:0]  hwInt_i;
    logic        resultValid_o;
    logic [31:0] resultData_o;
    logic        redirectValid_o;
    logic [31:0] redirectPc_o;
    logic        timerInt_o;
    logic        intPending_o;
    logic        userMode_o;

    int          valueErrs = 0;
    int          otherErrs = 0;
    logic [31:0] rngState = 32'd5;

    cp0Unit dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] mfc0Word(input logic [4:0] regNum);
        return {`OPC_COP0, `RS_MF, 5'd2, regNum, 8'd0, 3'd0};
    endfunction

    function automatic logic [31:0] mtc0Word(input logic [4:0] regNum);
        return {`OPC_COP0, `RS_MT, 5'd2, regNum, 8'd0, 3'd0};
    endfunction

    function automatic logic [31:0] eretWord();
        return {`OPC_COP0, 1'b1, 19'd0, `FUNCT_ERET};
    endfunction

    function automatic logic flagValue(input int sel);
        case (sel)
            FlagTimer: return timerInt_o;
            FlagInt:   return intPending_o;
            default:   return userMode_o;
        endcase
    endfunction

    task automatic compareWord(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            valueErrs++;
            $display("ERR %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic issueInstr(input logic [31:0] word, input logic [31:0] rt);
        @(posedge clk);
        instrValid_i <= 1'b1;
        instr_i      <= word;
        rtData_i     <= rt;
        @(posedge clk);
        instrValid_i <= 1'b0;
    endtask

    task automatic waitResult(output logic [31:0] data);
        int n;
        bit seen;
        seen = 0;
        for (n = 0; n < 20 && !seen; n++) begin
            @(negedge clk);
            seen = resultValid_o;
        end
        data = resultData_o;
        assert (seen) else begin
            otherErrs++;
            $display("Timeout while waiting for an MFC0 result");
        end
    endtask

    task automatic waitRedirect(output logic [31:0] pc);
        int n;
        bit seen;
        seen = 0;
        for (n = 0; n < 20 && !seen; n++) begin
            @(negedge clk);
            seen = redirectValid_o;
        end
        pc = redirectPc_o;
        assert (seen) else begin
            otherErrs++;
            $display("Timeout while waiting for a fetch redirect");
        end
    endtask

    task automatic waitFlag(input int sel, input logic want, input string name);
        int n;
        bit seen;
        seen = 0;
        for (n = 0; n < 100 && !seen; n++) begin
            @(negedge clk);
            seen = (flagValue(sel) == want);
        end
        assert (seen) else begin
            otherErrs++;
            $display("Timeout: %s never went to %0d", name, want);
        end
    endtask

    task automatic readReg(input logic [4:0] regNum, output logic [31:0] data);
        issueInstr(mfc0Word(regNum), 32'd0);
        waitResult(data);
    endtask

    task automatic writeReg(input logic [4:0] regNum, input logic [31:0] data);
        issueInstr(mtc0Word(regNum), data);
    endtask

    // MTC0 and MFC0 on consecutive cycles
    task automatic moveRoundTrip(input logic [4:0] regNum, input logic [31:0] wdata,
                                 output logic [31:0] rdata);
        @(posedge clk);
        instrValid_i <= 1'b1;
        instr_i      <= mtc0Word(regNum);
        rtData_i     <= wdata;
        @(posedge clk);
        instr_i      <= mfc0Word(regNum);
        @(posedge clk);
        instrValid_i <= 1'b0;
        waitResult(rdata);
    endtask

    task automatic raiseExc(input logic [4:0] code, input logic [31:0] pc,
                            input logic [31:0] bad, input logic inSlot);
        @(posedge clk);
        excValid_i    <= 1'b1;
        excCode_i     <= code;
        excPc_i       <= pc;
        excBadVAddr_i <= bad;
        excInSlot_i   <= inSlot;
        @(posedge clk);
        excValid_i    <= 1'b0;
    endtask

    task automatic testReset();
        logic [31:0] got;
        compareWord("resultValid_o", 32'd0, resultValid_o);
        compareWord("redirectValid_o", 32'd0, redirectValid_o);
        compareWord("timerInt_o", 32'd0, timerInt_o);
        readReg(`CP0_REG_PRID, got);
        compareWord("PrId", `PRID_VALUE, got);
        readReg(`CP0_REG_STATUS, got);
        compareWord("Status.BEV", 32'd1, got[22]);
        compareWord("Status.ERL", 32'd1, got[2]);
    endtask

    task automatic testFirstEret();
        logic [31:0] got;
        issueInstr(eretWord(), 32'd0);
        waitRedirect(got);
        compareWord("redirectPc_o", 32'd0, got); // EPC still at reset value
        readReg(`CP0_REG_STATUS, got);
        compareWord("Status.ERL", 32'd0, got[2]);
    endtask

    task automatic testMoves();
        logic [31:0] v;
        logic [31:0] got;
        v = nextRand();
        moveRoundTrip(`CP0_REG_EPC, v, got);
        compareWord("EPC", v, got);
        v = nextRand();
        moveRoundTrip(`CP0_REG_BADVADDR, v, got);
        compareWord("BadVAddr", v, got);
        v = nextRand();
        moveRoundTrip(`CP0_REG_COMPARE, v, got);
        compareWord("Compare", v, got);
        v = nextRand();
        moveRoundTrip(`CP0_REG_STATUS, v, got);
        compareWord("Status", v & `STATUS_WMASK, got);
        v = nextRand();
        moveRoundTrip(`CP0_REG_CAUSE, v, got);
        compareWord("Cause", v & `CAUSE_WMASK, got); // Only IP[1:0] writable here
        readReg(5'd3, got);
        compareWord("unknown register", 32'd0, got);
        v = nextRand();
        moveRoundTrip(`CP0_REG_COUNT, v, got);
        compareWord("Count", v, got);
    endtask

    task automatic testException();
        logic [31:0] pc;
        logic [31:0] bad;
        logic [31:0] got;
        writeReg(`CP0_REG_STATUS, 32'h00400000); // BEV only
        pc = nextRand() & 32'hFFFFFFFC;
        raiseExc(`EXC_SYS, pc, 32'd0, 1'b1);
        waitRedirect(got);
        compareWord("redirectPc_o", `VEC_BOOT, got);
        issueInstr(eretWord(), 32'd0);
        waitRedirect(got);
        compareWord("redirectPc_o", pc - 32'd4, got);

        writeReg(`CP0_REG_STATUS, 32'd0);
        pc  = nextRand() & 32'hFFFFFFFC;
        bad = nextRand();
        raiseExc(`EXC_ADEL, pc, bad, 1'b1);
        waitRedirect(got);
        compareWord("redirectPc_o", `VEC_NORMAL, got);
        readReg(`CP0_REG_EPC, got);
        compareWord("EPC", pc - 32'd4, got);
        readReg(`CP0_REG_CAUSE, got);
        compareWord("Cause.BD", 32'd1, got[31]);
        compareWord("Cause.ExcCode", `EXC_ADEL, got[6:2]);
        readReg(`CP0_REG_BADVADDR, got);
        compareWord("BadVAddr", bad, got);

        // Nested exception while EXL is set
        raiseExc(`EXC_SYS, pc + 32'h40, 32'd0, 1'b0);
        waitRedirect(got);
        compareWord("redirectPc_o", `VEC_NORMAL, got);
        readReg(`CP0_REG_EPC, got);
        compareWord("EPC", pc - 32'd4, got);

        issueInstr(eretWord(), 32'd0);
        waitRedirect(got);
        compareWord("redirectPc_o", pc - 32'd4, got);
        readReg(`CP0_REG_STATUS, got);
        compareWord("Status.EXL", 32'd0, got[1]);
    endtask

    task automatic testSuppress();
        int n;
        bit gotResult;
        bit gotRedirect;
        logic [31:0] pc;
        gotResult   = 0;
        gotRedirect = 0;
        @(posedge clk);
        instrValid_i <= 1'b1;
        instr_i      <= mfc0Word(`CP0_REG_PRID);
        @(posedge clk);
        instrValid_i <= 1'b0;
        excValid_i   <= 1'b1; // Meets the MFC0 in execute
        excCode_i    <= `EXC_OV;
        excPc_i      <= 32'h80002000;
        excInSlot_i  <= 1'b0;
        @(posedge clk);
        excValid_i   <= 1'b0;
        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            gotResult   = gotResult | resultValid_o;
            gotRedirect = gotRedirect | redirectValid_o;
        end
        assert (!gotResult) else begin
            otherErrs++;
            $display("MFC0 produced a result although an exception hit it in execute");
        end
        assert (gotRedirect) else begin
            otherErrs++;
            $display("Exception in execute gave no redirect");
        end
        issueInstr(eretWord(), 32'd0);
        waitRedirect(pc);
        compareWord("redirectPc_o", 32'h80002000, pc);
    endtask

    task automatic testTimer();
        logic [31:0] c;
        c = nextRand() | 32'h100;
        writeReg(`CP0_REG_COMPARE, c);
        writeReg(`CP0_REG_COUNT, c - 32'd20);
        waitFlag(FlagTimer, 1'b1, "timerInt_o");
        writeReg(`CP0_REG_COMPARE, c - 32'd1000); // Already behind Count
        waitFlag(FlagTimer, 1'b0, "timerInt_o");
    endtask

    task automatic testInterrupts();
        writeReg(`CP0_REG_STATUS, 32'h00000401); // IE and IM2
        @(posedge clk);
        hwInt_i <= 6'b000001;
        waitFlag(FlagInt, 1'b1, "intPending_o");
        writeReg(`CP0_REG_STATUS, 32'h00000403);
        waitFlag(FlagInt, 1'b0, "intPending_o");
        writeReg(`CP0_REG_STATUS, 32'h00000401);
        waitFlag(FlagInt, 1'b1, "intPending_o");
        writeReg(`CP0_REG_STATUS, 32'h00000001);
        waitFlag(FlagInt, 1'b0, "intPending_o");
        @(posedge clk);
        hwInt_i <= 6'd0;

        writeReg(`CP0_REG_STATUS, 32'h00000010);
        waitFlag(FlagUser, 1'b1, "userMode_o");
        writeReg(`CP0_REG_STATUS, 32'h00000012);
        waitFlag(FlagUser, 1'b0, "userMode_o");
        writeReg(`CP0_REG_STATUS, 32'h00000010);
        waitFlag(FlagUser, 1'b1, "userMode_o");
        writeReg(`CP0_REG_STATUS, 32'h00000014);
        waitFlag(FlagUser, 1'b0, "userMode_o");
    endtask

    initial begin
        rst           <= 1'b1;
        instrValid_i  <= 1'b0;
        instr_i       <= 32'd0;
        rtData_i      <= 32'd0;
        excValid_i    <= 1'b0;
        excCode_i     <= 5'd0;
        excPc_i       <= 32'd0;
        excBadVAddr_i <= 32'd0;
        excInSlot_i   <= 1'b0;
        excCpNum_i    <= 2'd0;
        hwInt_i       <= 6'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        testReset();
        testFirstEret();
        testMoves();
        testException();
        testSuppress();
        testTimer();
        testInterrupts();
        repeat (4) @(posedge clk);

        $display("Value errors: %0d, other errors: %0d", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
cp0_pkg.sv
cp0Decode.sv
cp0Regs.sv
cp0Result.sv
cp0Unit.sv
tb_cp0Unit.sv
